// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mem_stage_tb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== common/dmem_if.sv ====
interface dmem_if #(
  parameter int dmem_words = dmem_map_pkg::dmem_words_default
);
  import dmem_map_pkg::*;

  // word index width follows the depth
  localparam int idx_w = $clog2(dmem_words);

  // write enables, already qualified by the store strobe
  lane_en_t lane_we;
  // load request this cycle
  logic rd_strobe;
  // word address shared by all lanes
  logic [idx_w-1:0] index;
  // write bytes, already rotated onto their lanes
  byte_t [dmem_lanes-1:0] wdata;
  // read bytes, lane k driven by bank k
  byte_t [dmem_lanes-1:0] rdata;

  // request side, the stage logic
  modport stage (
    output lane_we,
    output rd_strobe,
    output index,
    output wdata
  );

  // each ram lane
  modport bank (
    input  lane_we,
    input  rd_strobe,
    input  index,
    input  wdata,
    output rdata
  );

  // load result side
  modport align (
    input rdata
  );

endinterface

// ==== common/dmem_map_pkg.sv ====
package dmem_map_pkg;

  ////////////////////
  // lane layout
  ////////////////////

  // one bank per byte of the word
  localparam int dmem_lanes = 4;
  localparam int lane_bits  = 8;

  // datum held by one bank
  typedef logic [lane_bits-1:0] byte_t;
  // byte offset inside a word
  typedef logic [$clog2(dmem_lanes)-1:0] lane_off_t;
  // one enable bit per lane
  typedef logic [dmem_lanes-1:0] lane_en_t;

  ////////////////////
  // depth
  ////////////////////

  // words per bank unless the top overrides it
  localparam int dmem_words_default = 256;

endpackage

// ==== common/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  ////////////////////
  // widths
  ////////////////////

  // integer register width
  localparam int xlen = 32;
  // register file has 32 entries
  localparam int reg_idx_w = 5;

  // data or address word
  typedef logic [xlen-1:0] word_t;
  // register number
  typedef logic [reg_idx_w-1:0] reg_idx_t;

  ////////////////////
  // memory controls
  ////////////////////

  // store width, one-hot as decoded in the pipeline
  typedef enum logic [2:0] {
    st_none = 3'b000,
    st_byte = 3'b001,
    st_half = 3'b010,
    st_word = 3'b100
  } store_ctrl_e;

  // load width and sign handling, one-hot
  typedef enum logic [4:0] {
    ld_none = 5'b00000,
    // signed byte
    ld_b    = 5'b00001,
    // signed half
    ld_h    = 5'b00010,
    ld_w    = 5'b00100,
    // unsigned byte
    ld_bu   = 5'b01000,
    // unsigned half
    ld_hu   = 5'b10000
  } load_ctrl_e;

endpackage

// ==== hw/dmem_bank.sv ====
module dmem_bank #(
  parameter int dmem_words = dmem_map_pkg::dmem_words_default,
  parameter int lane       = 0
) (
  input logic  clk,
  dmem_if.bank mem
);
  import dmem_map_pkg::*;

  localparam int idx_w = $clog2(dmem_words);

  // one byte per word for this lane
  byte_t ram [dmem_words];

  logic [idx_w-1:0] addr;

  assign addr = mem.index;

  ////////////////////
  // ram port
  ////////////////////

  // read-before-write, same-address access returns old byte
  always_ff @(posedge clk) begin
    if (mem.lane_we[lane]) begin
      ram[addr] <= mem.wdata[lane];
    end
    // holds last value when no read
    if (mem.rd_strobe) begin
      mem.rdata[lane] <= ram[addr];
    end
  end

endmodule

// ==== hw/mem_stage_top.sv ====
module mem_stage_top #(
  parameter int dmem_words = dmem_map_pkg::dmem_words_default
) (
  input  logic                     clk,
  input  logic                     rst,
  input  rv_pipe_pkg::word_t       ex_alu_res,
  input  rv_pipe_pkg::word_t       ex_rs2_data,
  input  rv_pipe_pkg::reg_idx_t    ex_rs2,
  input  rv_pipe_pkg::reg_idx_t    ex_rd,
  input  logic                     ex_regwrite,
  input  logic                     ex_memread,
  input  logic                     ex_memwrite,
  input  rv_pipe_pkg::store_ctrl_e ex_store_ctrl,
  input  rv_pipe_pkg::load_ctrl_e  ex_load_ctrl,
  input  rv_pipe_pkg::word_t       wb_res,
  output rv_pipe_pkg::word_t       mem_wb_alu_res,
  output rv_pipe_pkg::reg_idx_t    mem_wb_rd,
  output logic                     mem_wb_regwrite,
  output logic                     mem_wb_memread,
  output rv_pipe_pkg::word_t       mem_wb_mem_res
);
  import rv_pipe_pkg::*;
  import dmem_map_pkg::*;

  // registered controls for the aligner
  load_ctrl_e mem_wb_load_ctrl;
  lane_off_t  mem_wb_offset;

  // stage to banks to aligner
  dmem_if #(.dmem_words(dmem_words)) mem_if ();

  mem_access #(
    .dmem_words(dmem_words)
  ) mem_access_inst (
    .clk             (clk),
    .rst             (rst),
    .ex_alu_res      (ex_alu_res),
    .ex_rs2_data     (ex_rs2_data),
    .ex_rs2          (ex_rs2),
    .ex_rd           (ex_rd),
    .ex_regwrite     (ex_regwrite),
    .ex_memread      (ex_memread),
    .ex_memwrite     (ex_memwrite),
    .ex_store_ctrl   (ex_store_ctrl),
    .ex_load_ctrl    (ex_load_ctrl),
    .wb_res          (wb_res),
    .mem             (mem_if.stage),
    .mem_wb_alu_res  (mem_wb_alu_res),
    .mem_wb_rd       (mem_wb_rd),
    .mem_wb_regwrite (mem_wb_regwrite),
    .mem_wb_memread  (mem_wb_memread),
    .mem_wb_load_ctrl(mem_wb_load_ctrl),
    .mem_wb_offset   (mem_wb_offset)
  );

  // one byte-wide bank per lane
  for (genvar i = 0; i < dmem_lanes; i++) begin : g_bank
    dmem_bank #(
      .dmem_words(dmem_words),
      .lane      (i)
    ) dmem_bank_inst (
      .clk(clk),
      .mem(mem_if.bank)
    );
  end

  load_align load_align_inst (
    .mem      (mem_if.align),
    .offset   (mem_wb_offset),
    .load_ctrl(mem_wb_load_ctrl),
    .mem_res  (mem_wb_mem_res)
  );

endmodule

// ==== mem_stage/load_align.sv ====
module load_align (
  dmem_if.align                   mem,
  input  dmem_map_pkg::lane_off_t offset,
  input  rv_pipe_pkg::load_ctrl_e load_ctrl,
  output rv_pipe_pkg::word_t      mem_res
);
  import rv_pipe_pkg::*;
  import dmem_map_pkg::*;

  word_t             raw_word;
  logic [2*xlen-1:0] rot_dbl;
  word_t             aligned;

  ////////////////////
  // lane reassembly
  ////////////////////

  // lane 0 is the low byte
  assign raw_word = mem.rdata;

  // rotate right so the addressed byte sits at bit 0
  assign rot_dbl = {raw_word, raw_word} >> {offset, 3'b000};
  assign aligned = rot_dbl[xlen-1:0];

  ////////////////////
  // extension
  ////////////////////

  always_comb begin
    case (load_ctrl)
      // lb, sign from bit 7
      ld_b: mem_res = {{(xlen-8){aligned[7]}}, aligned[7:0]};
      // lh, sign from bit 15
      ld_h: mem_res = {{(xlen-16){aligned[15]}}, aligned[15:0]};
      ld_w: mem_res = aligned;
      ld_bu: mem_res = {{(xlen-8){1'b0}}, aligned[7:0]};
      ld_hu: mem_res = {{(xlen-16){1'b0}}, aligned[15:0]};
      // no load in MEM/WB
      default: mem_res = '0;
    endcase
  end

endmodule

// ==== mem_stage/mem_access.sv ====
module mem_access #(
  parameter int dmem_words = dmem_map_pkg::dmem_words_default
) (
  input  logic                     clk,
  input  logic                     rst,
  input  rv_pipe_pkg::word_t       ex_alu_res,
  input  rv_pipe_pkg::word_t       ex_rs2_data,
  input  rv_pipe_pkg::reg_idx_t    ex_rs2,
  input  rv_pipe_pkg::reg_idx_t    ex_rd,
  input  logic                     ex_regwrite,
  input  logic                     ex_memread,
  input  logic                     ex_memwrite,
  input  rv_pipe_pkg::store_ctrl_e ex_store_ctrl,
  input  rv_pipe_pkg::load_ctrl_e  ex_load_ctrl,
  input  rv_pipe_pkg::word_t       wb_res,
  dmem_if.stage                    mem,
  output rv_pipe_pkg::word_t       mem_wb_alu_res,
  output rv_pipe_pkg::reg_idx_t    mem_wb_rd,
  output logic                     mem_wb_regwrite,
  output logic                     mem_wb_memread,
  output rv_pipe_pkg::load_ctrl_e  mem_wb_load_ctrl,
  output dmem_map_pkg::lane_off_t  mem_wb_offset
);
  import rv_pipe_pkg::*;
  import dmem_map_pkg::*;

  localparam int idx_w = $clog2(dmem_words);
  localparam int off_w = $bits(lane_off_t);

  lane_off_t             offset;
  lane_en_t              base_en;
  logic [2*dmem_lanes-1:0] en_dbl;
  logic                  fwd_sel;
  word_t                 st_data;
  logic [2*xlen-1:0]     data_dbl;

  // low address bits pick the starting lane
  assign offset = ex_alu_res[off_w-1:0];

  ////////////////////
  // lane enables
  ////////////////////

  always_comb begin
    case (ex_store_ctrl)
      st_byte: base_en = 4'b0001;
      st_half: base_en = 4'b0011;
      // sw and no store control both cover the whole word
      st_word, st_none: base_en = 4'b1111;
      default: base_en = 4'b1111;
    endcase
    // rotate left by offset, sh at offset 3 wraps to lanes 3 and 0
    en_dbl = {base_en, base_en} << offset;
  end

  // nothing is written without the store strobe
  assign mem.lane_we = ex_memwrite ? en_dbl[2*dmem_lanes-1 -: dmem_lanes] : '0;

  ////////////////////
  // store forwarding
  ////////////////////

  // rs2 being written back by the instruction now in MEM/WB
  assign fwd_sel = ex_memwrite && mem_wb_regwrite && (mem_wb_rd == ex_rs2);
  assign st_data = fwd_sel ? wb_res : ex_rs2_data;

  ////////////////////
  // lane steering
  ////////////////////

  // byte k lands on lane (offset + k) mod 4
  assign data_dbl  = {st_data, st_data} << {offset, 3'b000};
  assign mem.wdata = data_dbl[2*xlen-1 -: xlen];

  // word index and read request
  assign mem.index     = ex_alu_res[off_w +: idx_w];
  assign mem.rd_strobe = ex_memread;

  ////////////////////
  // MEM/WB register
  ////////////////////

  // advances every edge, no stall
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_alu_res   <= '0;
      mem_wb_rd        <= '0;
      mem_wb_regwrite  <= 1'b0;
      mem_wb_memread   <= 1'b0;
      mem_wb_load_ctrl <= ld_none;
      mem_wb_offset    <= '0;
    end else begin
      mem_wb_alu_res   <= ex_alu_res;
      mem_wb_rd        <= ex_rd;
      mem_wb_regwrite  <= ex_regwrite;
      mem_wb_memread   <= ex_memread;
      // aligner needs these alongside the registered bank data
      mem_wb_load_ctrl <= ex_load_ctrl;
      mem_wb_offset    <= offset;
    end
  end

endmodule

// ==== sources.f ====
+incdir+tb
common/rv_pipe_pkg.sv
common/dmem_map_pkg.sv
common/dmem_if.sv
mem_stage/mem_access.sv
mem_stage/load_align.sv
hw/dmem_bank.sv
hw/mem_stage_top.sv
tb/mem_stage_tb.sv

// ==== tb/mem_ref_model.svh ====
`ifndef mem_ref_model_svh
`define mem_ref_model_svh

////////////////////
// reference memory
////////////////////

// flat byte array, byte address is index * 4 + lane
byte_t ref_mem [ref_words*dmem_lanes];

// byte held on one lane of a word
function automatic byte_t lane_byte(word_t w, lane_off_t l);
  return w[l*8 +: 8];
endfunction

// lanes a store touches, none without the write strobe
function automatic lane_en_t ref_lane_en(store_ctrl_e sc, lane_off_t off, logic we);
  lane_en_t  en;
  lane_off_t nxt;
  en  = '0;
  nxt = off + 2'd1;
  if (we) begin
    case (sc)
      st_byte: en[off] = 1'b1;
      // half at offset 3 wraps to lane 0
      st_half: begin
        en[off] = 1'b1;
        en[nxt] = 1'b1;
      end
      default: en = '1;
    endcase
  end
  return en;
endfunction

// byte k of the data goes to lane off + k
task automatic ref_store(int idx, lane_off_t off, lane_en_t en, word_t data);
  lane_off_t ln;
  for (int k = 0; k < dmem_lanes; k++) begin
    ln = lane_off_t'(off + k);
    if (en[ln]) begin
      ref_mem[idx*dmem_lanes + ln] = data[k*8 +: 8];
    end
  end
endtask

function automatic word_t ref_read_word(int idx);
  return {ref_mem[idx*4+3], ref_mem[idx*4+2], ref_mem[idx*4+1], ref_mem[idx*4]};
endfunction

// pick bytes from the offset upward, then extend
function automatic word_t ref_load(word_t w, lane_off_t off, load_ctrl_e lc);
  byte_t b0;
  byte_t b1;
  byte_t b2;
  byte_t b3;
  b0 = lane_byte(w, off);
  b1 = lane_byte(w, off + 2'd1);
  b2 = lane_byte(w, off + 2'd2);
  b3 = lane_byte(w, off + 2'd3);
  case (lc)
    ld_b:    return {{24{b0[7]}}, b0};
    ld_h:    return {{16{b1[7]}}, b1, b0};
    ld_w:    return {b3, b2, b1, b0};
    ld_bu:   return {24'd0, b0};
    ld_hu:   return {16'd0, b1, b0};
    default: return '0;
  endcase
endfunction

`endif

// ==== tb/mem_stage_tb.sv ====
module mem_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_pipe_pkg::*;
  import dmem_map_pkg::*;

  localparam int ref_words = dmem_words_default;
  localparam int ref_idx_w = $clog2(ref_words);
  // reset, fill, pass-through, word, partial, extension, forwarding
  localparam int stim_cycles = 20 + ref_words + 200 + 144 + 96 + 34 + 144;
  localparam int timeout_cycles = 3 * stim_cycles;
  localparam word_t word_mask = 32'hffff_fffc;

  logic        clk;
  logic        rst;
  word_t       ex_alu_res;
  word_t       ex_rs2_data;
  reg_idx_t    ex_rs2;
  reg_idx_t    ex_rd;
  logic        ex_regwrite;
  logic        ex_memread;
  logic        ex_memwrite;
  store_ctrl_e ex_store_ctrl;
  load_ctrl_e  ex_load_ctrl;
  word_t       wb_res;
  word_t       mem_wb_alu_res;
  reg_idx_t    mem_wb_rd;
  logic        mem_wb_regwrite;
  logic        mem_wb_memread;
  word_t       mem_wb_mem_res;

  // expected MEM/WB values, one cycle behind the inputs
  word_t       exp_alu_res;
  word_t       exp_mem_res;
  reg_idx_t    exp_rd;
  logic        exp_regwrite;
  logic        exp_memread;
  logic        exp_valid = 1'b0;
  // last word the banks registered
  word_t       held_word = '0;
  string       test_name = "reset";
  int unsigned lcg_state = 397;
  int          cycle_count = 0;

  `include "mem_ref_model.svh"

  mem_stage_top #(.dmem_words(ref_words)) mem_stage_top_inst (
    .clk(clk), .rst(rst), .ex_alu_res(ex_alu_res), .ex_rs2_data(ex_rs2_data),
    .ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_regwrite(ex_regwrite), .ex_memread(ex_memread),
    .ex_memwrite(ex_memwrite), .ex_store_ctrl(ex_store_ctrl), .ex_load_ctrl(ex_load_ctrl),
    .wb_res(wb_res), .mem_wb_alu_res(mem_wb_alu_res), .mem_wb_rd(mem_wb_rd),
    .mem_wb_regwrite(mem_wb_regwrite), .mem_wb_memread(mem_wb_memread),
    .mem_wb_mem_res(mem_wb_mem_res)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  // lcg, upper bits are the better ones
  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned pick(int unsigned n);
    return (next_rand() >> 8) % n;
  endfunction

  task automatic report_mismatch(string field, word_t expected, word_t actual);
    $display("mismatch %s %s: expected %h actual %h", test_name, field, expected, actual);
    $display("Result: FAILED");
    $fatal(1, "output check failed");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_idle();
    ex_alu_res    = '0;
    ex_rs2_data   = '0;
    ex_rs2        = '0;
    ex_rd         = '0;
    ex_regwrite   = 1'b0;
    ex_memread    = 1'b0;
    ex_memwrite   = 1'b0;
    ex_store_ctrl = st_none;
    ex_load_ctrl  = ld_none;
    wb_res        = '0;
  endtask

  task automatic do_store(word_t addr, word_t data, store_ctrl_e sc, logic we,
                          reg_idx_t rs2, word_t wb);
    drive_idle();
    ex_alu_res    = addr;
    ex_rs2_data   = data;
    ex_rs2        = rs2;
    ex_memwrite   = we;
    ex_store_ctrl = sc;
    wb_res        = wb;
    next_cycle();
  endtask

  task automatic do_load(word_t addr, load_ctrl_e lc);
    drive_idle();
    ex_alu_res   = addr;
    ex_memread   = 1'b1;
    ex_load_ctrl = lc;
    next_cycle();
  endtask

  // alu record that writes back rd
  task automatic set_producer(reg_idx_t rd, logic regwrite);
    drive_idle();
    ex_alu_res  = next_rand();
    ex_rd       = rd;
    ex_regwrite = regwrite;
    next_cycle();
  endtask

  task automatic drive_random();
    word_t r;
    r = next_rand();
    ex_alu_res  = next_rand();
    ex_rs2_data = next_rand();
    wb_res      = next_rand();
    ex_rs2      = r[20:16];
    // never rd 0
    ex_rd       = reg_idx_t'(1 + pick(31));
    ex_regwrite = r[24];
    ex_memread  = r[25];
    ex_memwrite = r[26];
    case (r[29:28])
      2'd0: ex_store_ctrl = st_none;
      2'd1: ex_store_ctrl = st_byte;
      2'd2: ex_store_ctrl = st_half;
      default: ex_store_ctrl = st_word;
    endcase
    // load control only with a read
    ex_load_ctrl = ld_none;
    if (ex_memread) begin
      case (pick(5))
        0: ex_load_ctrl = ld_b;
        1: ex_load_ctrl = ld_h;
        2: ex_load_ctrl = ld_w;
        3: ex_load_ctrl = ld_bu;
        default: ex_load_ctrl = ld_hu;
      endcase
    end
    next_cycle();
  endtask

  ////////////////////
  // reference update
  ////////////////////

  always @(posedge clk) begin : ref_update
    int        idx;
    lane_off_t off;
    word_t     st;
    exp_valid <= 1'b1;
    if (rst) begin
      exp_alu_res  <= '0;
      exp_rd       <= '0;
      exp_regwrite <= 1'b0;
      exp_memread  <= 1'b0;
      exp_mem_res  <= '0;
    end else begin
      idx = int'(ex_alu_res[2 +: ref_idx_w]);
      off = ex_alu_res[1:0];
      // read sees the word before this cycle's write
      if (ex_memread) begin
        held_word = ref_read_word(idx);
      end
      // forward from the record now in MEM/WB
      st = (ex_memwrite && exp_regwrite && exp_rd == ex_rs2) ? wb_res : ex_rs2_data;
      ref_store(idx, off, ref_lane_en(ex_store_ctrl, off, ex_memwrite), st);
      exp_alu_res  <= ex_alu_res;
      exp_rd       <= ex_rd;
      exp_regwrite <= ex_regwrite;
      exp_memread  <= ex_memread;
      exp_mem_res  <= ref_load(held_word, off, ex_load_ctrl);
    end
  end

  ////////////////////
  // output checks
  ////////////////////

  assert property (@(posedge clk) exp_valid |-> mem_wb_alu_res == exp_alu_res)
    else report_mismatch("alu_res", $sampled(exp_alu_res), $sampled(mem_wb_alu_res));
  assert property (@(posedge clk) exp_valid |-> mem_wb_rd == exp_rd)
    else report_mismatch("rd", word_t'($sampled(exp_rd)), word_t'($sampled(mem_wb_rd)));
  assert property (@(posedge clk) exp_valid |-> mem_wb_regwrite == exp_regwrite)
    else report_mismatch("regwrite", word_t'($sampled(exp_regwrite)),
                         word_t'($sampled(mem_wb_regwrite)));
  assert property (@(posedge clk) exp_valid |-> mem_wb_memread == exp_memread)
    else report_mismatch("memread", word_t'($sampled(exp_memread)),
                         word_t'($sampled(mem_wb_memread)));
  assert property (@(posedge clk) exp_valid |-> mem_wb_mem_res == exp_mem_res)
    else report_mismatch("mem_res", $sampled(exp_mem_res), $sampled(mem_wb_mem_res));

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run went past %0d cycles", timeout_cycles);
      $display("Result: FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : stimulus
    word_t    addrs [64];
    word_t    base;
    reg_idx_t r;
    drive_idle();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    // idle record right after reset
    next_cycle();

    // every word gets a value tied to its address
    test_name = "fill";
    for (int i = 0; i < ref_words; i++) begin
      do_store(word_t'(i) << 2, word_t'(i + 1) * 32'h9e37_79b1, st_word, 1'b1, 5'd0, '0);
    end

    test_name = "pass_through";
    repeat (200) drive_random();

    test_name = "word_round_trip";
    for (int i = 0; i < 64; i++) begin
      addrs[i] = next_rand() & word_mask;
      do_store(addrs[i], next_rand(), st_word, 1'b1, 5'd0, next_rand());
    end
    // store control without the strobe
    for (int i = 0; i < 16; i++) begin
      do_store(addrs[i*4], next_rand(), st_word, 1'b0, 5'd0, next_rand());
    end
    for (int i = 0; i < 64; i++) begin
      do_load(addrs[i], ld_w);
    end

    // offset 3 covers the half wrap
    test_name = "partial_store";
    for (int w = 0; w < 8; w++) begin
      base = next_rand() & word_mask;
      for (int off = 0; off < dmem_lanes; off++) begin
        do_store(base + word_t'(off), next_rand(), st_byte, 1'b1, 5'd0, '0);
        do_store(base + word_t'(off), next_rand(), st_half, 1'b1, 5'd0, '0);
        do_load(base, ld_w);
      end
    end

    // sign bits all set, then all clear
    test_name = "load_extend";
    for (int p = 0; p < 2; p++) begin
      base = next_rand() & word_mask;
      do_store(base, (p == 0) ? 32'h8af3_9ce1 : 32'h3a71_5c24, st_word, 1'b1, 5'd0, '0);
      for (int off = 0; off < dmem_lanes; off++) begin
        do_load(base + word_t'(off), ld_b);
        do_load(base + word_t'(off), ld_h);
        do_load(base + word_t'(off), ld_bu);
        do_load(base + word_t'(off), ld_hu);
      end
    end

    // match, rd mismatch, regwrite clear
    test_name = "forwarding";
    for (int i = 0; i < 48; i++) begin
      base = next_rand() & word_mask;
      r = reg_idx_t'(1 + pick(31));
      case (i % 3)
        0: set_producer(r, 1'b1);
        1: set_producer(reg_idx_t'(r % 31 + 1), 1'b1);
        default: set_producer(r, 1'b0);
      endcase
      do_store(base, next_rand(), st_word, 1'b1, r, next_rand());
      do_load(base, ld_w);
    end

    test_name = "drain";
    drive_idle();
    next_cycle();
    next_cycle();
    $display("Result: PASSED");
    $finish;
  end

endmodule
